/* logic/console_rom.hex */
// console ROM image, one 16-bit word per line, word 0 first
83E0
0024
0900
1234
5678
9ABC
DEF0
0F0F
C3A5
4E5F
6B7C
8D9E
A1B2
C3D4
E5F6
1357

/* testbench/console_bus_testdata.txt */
# port op address sel wdata expected
# port is cpu, dbg or both; op is r or w; the rest is hex, byte addresses
cpu r 0000 3 0000 83E0
cpu r 0006 3 0000 1234
dbg r 001E 3 0000 1357
cpu r 1FE8 3 0000 5678
cpu w 0006 3 FFFF 0000
dbg r 0006 3 0000 1234
cpu w 8000 3 A1B2 0000
cpu r 8000 3 0000 A1B2
dbg w 8000 2 5500 0000
dbg r 8000 3 0000 55B2
cpu w 8000 1 0066 0000
cpu r 8000 3 0000 5566
dbg r 8100 3 0000 5566
cpu w 83FE 3 BEEF 0000
dbg r 80FE 3 0000 BEEF
cpu w 2010 3 C0DE 0000
cpu r 2010 3 0000 C0DE
dbg w 2010 1 0042 0000
dbg r 2010 3 0000 C042
cpu w 2010 2 7700 0000
cpu r 2010 2 0000 77FF
dbg r 2010 1 0000 FF42
cpu r 3F10 3 0000 7742
cpu r 4000 3 0000 FFFF
dbg r C000 3 0000 FFFF
cpu w 8400 3 1111 0000
dbg r 8000 3 0000 5566
cpu w 4010 3 2222 0000
dbg r 2010 3 0000 7742
dbg w C000 3 3333 0000
cpu r 8400 3 0000 FFFF
both r 0002 3 0000 0024
dbg r 8100 3 0000 5566
both r 2010 3 0000 7742
cpu r C000 3 0000 FFFF
both w 8004 3 4D5E 0000
dbg r 8004 3 0000 4D5E
both r 8004 3 0000 4D5E

/* console_bus.f */
logic/console_pkg.sv
logic/wb_bus_if.sv
logic/bus_arbiter.sv
logic/address_decoder.sv
logic/console_rom.sv
logic/scratchpad_ram.sv
logic/byte_multiplexer.sv
logic/expansion_ram.sv
logic/console_bus.sv
testbench/tb_console_bus.sv

/* Makefile */
# Verilator flow for the console memory bus, run from the project root

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f console_bus.f --top-module console_bus
	verilator --lint-only --timing -f console_bus.f --top-module tb_console_bus

sim:
	verilator --binary --timing -f console_bus.f --top-module tb_console_bus
	@out="$$(./obj_dir/Vtb_console_bus)"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

/* testbench/tb_console_bus.sv */
`timescale 1ns/1ps

module tb_console_bus import console_pkg::*; ();

   localparam int reset_cycles = 10;
   localparam int max_vectors = 64;
   localparam int cycles_per_vector = 20;

   logic clk = 1'b0;
   logic arst_n_i;

   logic cpu_cyc;
   logic cpu_stb;
   logic cpu_we;
   waddr_t cpu_adr;
   logic [1:0] cpu_sel;
   word_t cpu_dat_w;
   word_t cpu_dat_r;
   logic cpu_ack;
   logic dbg_cyc;
   logic dbg_stb;
   logic dbg_we;
   waddr_t dbg_adr;
   logic [1:0] dbg_sel;
   word_t dbg_dat_w;
   word_t dbg_dat_r;
   logic dbg_ack;

   // one entry per vector line where port 0 is the cpu, 1 the debug host and 2 both
   logic [1:0] vec_port [max_vectors];
   logic vec_we [max_vectors];
   logic [15:0] vec_adr [max_vectors];
   logic [1:0] vec_sel [max_vectors];
   word_t vec_wdat [max_vectors];
   word_t vec_exp [max_vectors];
   int n_vec = 0;

   word_t rom_img [rom_words];
   logic ack_order [$]; // a 1 marks an ack of the debug host
   logic last_dbg = 1'b0; // after reset the cpu counts as served last
   int errors = 0;
   int checks = 0;
   int cycle_count = 0;
   int cycle_limit = 0;

   always #4 clk = ~clk;

   console_bus UUT (
      .clk(clk), .arst_n_i(arst_n_i),
      .cpu_cyc_i(cpu_cyc), .cpu_stb_i(cpu_stb), .cpu_we_i(cpu_we), .cpu_adr_i(cpu_adr),
      .cpu_sel_i(cpu_sel), .cpu_dat_i(cpu_dat_w), .cpu_dat_o(cpu_dat_r), .cpu_ack_o(cpu_ack),
      .dbg_cyc_i(dbg_cyc), .dbg_stb_i(dbg_stb), .dbg_we_i(dbg_we), .dbg_adr_i(dbg_adr),
      .dbg_sel_i(dbg_sel), .dbg_dat_i(dbg_dat_w), .dbg_dat_o(dbg_dat_r), .dbg_ack_o(dbg_ack)
   );

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("Timeout: ack never arrived within %0d cycles", cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   function automatic string port_name(input logic on_dbg);
      if (on_dbg) return "dbg";
      return "cpu";
   endfunction

   task automatic drive_port(input logic on_dbg, input logic active, input logic we,
                             input logic [15:0] adr, input logic [1:0] sel, input word_t dat);
      if (on_dbg) begin
         dbg_cyc = active;
         dbg_stb = active;
         dbg_we = we;
         dbg_adr = adr[15:1]; // the bus carries word addresses
         dbg_sel = sel;
         dbg_dat_w = dat;
      end else begin
         cpu_cyc = active;
         cpu_stb = active;
         cpu_we = we;
         cpu_adr = adr[15:1];
         cpu_sel = sel;
         cpu_dat_w = dat;
      end
   endtask

   task automatic read_vectors();
      int fd;
      int code;
      int fields;
      string line;
      logic [31:0] port_s;
      logic [7:0] op_s;
      logic [15:0] adr;
      logic [1:0] sel;
      word_t wdat;
      word_t exp_dat;
      fd = $fopen("testbench/console_bus_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the test vector file");
         errors++;
      end else begin
         while (!$feof(fd) && n_vec < max_vectors) begin
            code = $fgets(line, fd);
            fields = 0;
            if (code != 0) begin
               fields = $sscanf(line, "%s %s %h %h %h %h",
                                port_s, op_s, adr, sel, wdat, exp_dat);
            end
            if (fields == 6) begin // comment and blank lines fall out here
               if (port_s == 32'("cpu")) vec_port[n_vec] = 2'd0;
               else if (port_s == 32'("dbg")) vec_port[n_vec] = 2'd1;
               else vec_port[n_vec] = 2'd2;
               vec_we[n_vec] = (op_s == "w");
               vec_adr[n_vec] = adr;
               vec_sel[n_vec] = sel;
               vec_wdat[n_vec] = wdat;
               vec_exp[n_vec] = exp_dat;
               n_vec++;
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic check_read(input logic on_dbg, input int k, input word_t seen);
      word_t img;
      checks++;
      if (seen !== vec_exp[k]) begin
         errors++;
         $display("Mismatch at %0t: %s read of address %h expected %h seen %h",
                  $time, port_name(on_dbg), vec_adr[k], vec_exp[k], seen);
      end
      // ROM words repeat every 16 words across the region
      if ((vec_adr[k] - rom_base) < rom_size) begin
         img = rom_img[vec_adr[k][4:1]];
         checks++;
         if (seen !== img) begin
            errors++;
            $display("Mismatch at %0t: %s read of ROM address %h expected image word %h seen %h",
                     $time, port_name(on_dbg), vec_adr[k], img, seen);
         end
      end
   endtask

   task automatic run_access(input logic on_dbg, input int k);
      logic got_ack;
      word_t seen;
      @(posedge clk);
      #1;
      drive_port(on_dbg, 1'b1, vec_we[k], vec_adr[k], vec_sel[k], vec_wdat[k]);
      got_ack = 1'b0;
      while (!got_ack) begin
         @(negedge clk);
         got_ack = on_dbg ? dbg_ack : cpu_ack;
      end
      seen = on_dbg ? dbg_dat_r : cpu_dat_r;
      ack_order.push_back(on_dbg);
      if (!vec_we[k]) check_read(on_dbg, k, seen);
      @(posedge clk);
      #1;
      drive_port(on_dbg, 1'b0, 1'b0, 16'h0000, 2'b00, 16'h0000);
   endtask

   // by round robin the master that did not go last gets the first ack
   task automatic check_order(input int k);
      logic first_dbg;
      first_dbg = !last_dbg;
      checks++;
      if (ack_order[0] !== first_dbg) begin
         errors++;
         $display("Mismatch at %0t: paired line %0d expected first ack from %s seen from %s",
                  $time, k, port_name(first_dbg), port_name(ack_order[0]));
      end
      last_dbg = ack_order[1];
   endtask

   initial begin
      arst_n_i = 1'b0;
      drive_port(1'b0, 1'b0, 1'b0, 16'h0000, 2'b00, 16'h0000);
      drive_port(1'b1, 1'b0, 1'b0, 16'h0000, 2'b00, 16'h0000);
      $readmemh(rom_image, rom_img);
      read_vectors();
      if (n_vec == 0) begin
         $display("No test vectors were read");
         errors++;
      end
      cycle_limit = n_vec * cycles_per_vector + reset_cycles;
      repeat (reset_cycles) @(posedge clk);
      #1;
      arst_n_i = 1'b1;
      for (int k = 0; k < n_vec; k++) begin
         ack_order.delete();
         if (vec_port[k] == 2'd2) begin
            fork
               run_access(1'b0, k);
               run_access(1'b1, k);
            join
            check_order(k);
         end else begin
            run_access(vec_port[k] == 2'd1, k);
            last_dbg = (vec_port[k] == 2'd1);
         end
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* logic/console_bus.sv */
`timescale 1ns/1ps

module console_bus import console_pkg::*; (
   input logic clk,
   input logic arst_n_i,
   input logic cpu_cyc_i,
   input logic cpu_stb_i,
   input logic cpu_we_i,
   input waddr_t cpu_adr_i,
   input logic [1:0] cpu_sel_i,
   input word_t cpu_dat_i,
   output word_t cpu_dat_o,
   output logic cpu_ack_o,
   input logic dbg_cyc_i,
   input logic dbg_stb_i,
   input logic dbg_we_i,
   input waddr_t dbg_adr_i,
   input logic [1:0] dbg_sel_i,
   input word_t dbg_dat_i,
   output word_t dbg_dat_o,
   output logic dbg_ack_o
);

   wb_bus_if #(.data_t(word_t)) cpu_bus ();
   wb_bus_if #(.data_t(word_t)) dbg_bus ();
   wb_bus_if #(.data_t(word_t)) shared_bus ();
   wb_bus_if #(.data_t(word_t)) rom_bus ();
   wb_bus_if #(.data_t(word_t)) scratch_bus ();
   wb_bus_if #(.data_t(word_t)) exp_word_bus ();
   wb_bus_if #(.data_t(byte_t)) exp_byte_bus (); // 8-bit side of the expansion port

   assign cpu_bus.cyc = cpu_cyc_i;
   assign cpu_bus.stb = cpu_stb_i;
   assign cpu_bus.we = cpu_we_i;
   assign cpu_bus.adr = cpu_adr_i;
   assign cpu_bus.sel = cpu_sel_i;
   assign cpu_bus.dat_w = cpu_dat_i;
   assign cpu_dat_o = cpu_bus.dat_r;
   assign cpu_ack_o = cpu_bus.ack;

   assign dbg_bus.cyc = dbg_cyc_i;
   assign dbg_bus.stb = dbg_stb_i;
   assign dbg_bus.we = dbg_we_i;
   assign dbg_bus.adr = dbg_adr_i;
   assign dbg_bus.sel = dbg_sel_i;
   assign dbg_bus.dat_w = dbg_dat_i;
   assign dbg_dat_o = dbg_bus.dat_r;
   assign dbg_ack_o = dbg_bus.ack;

   bus_arbiter arb (
      .clk(clk), .arst_n_i(arst_n_i),
      .cpu_m(cpu_bus.slave), .dbg_m(dbg_bus.slave), .shared_o(shared_bus.master)
   );

   address_decoder dec (
      .clk(clk), .arst_n_i(arst_n_i), .shared_i(shared_bus.slave),
      .rom_o(rom_bus.master), .scratch_o(scratch_bus.master), .exp_o(exp_word_bus.master)
   );

   console_rom rom (.clk(clk), .arst_n_i(arst_n_i), .bus_s(rom_bus.slave));

   scratchpad_ram ram (.clk(clk), .arst_n_i(arst_n_i), .bus_s(scratch_bus.slave));

   byte_multiplexer mpx (
      .clk(clk), .arst_n_i(arst_n_i),
      .word_s(exp_word_bus.slave), .byte_m(exp_byte_bus.master)
   );

   expansion_ram exp_ram (.clk(clk), .arst_n_i(arst_n_i), .bus_s(exp_byte_bus.slave));

endmodule

/* logic/expansion_ram.sv */
`timescale 1ns/1ps

module expansion_ram import console_pkg::*; (
   input logic clk,
   input logic arst_n_i,
   wb_bus_if.slave bus_s
);

   localparam int idx_w = $clog2(exp_bytes);

   byte_t mem [exp_bytes];
   byte_t dat_q;
   logic ack_q;
   logic access;
   logic [idx_w-1:0] idx;

   assign access = bus_s.cyc && bus_s.stb && !ack_q;
   assign idx = bus_s.adr[idx_w-1:0]; // byte address, mirrored over the window

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) ack_q <= 1'b0;
      else ack_q <= access;
   end

   always_ff @(posedge clk) begin
      if (access && bus_s.we && bus_s.sel[0]) mem[idx] <= bus_s.dat_w;
      dat_q <= mem[idx];
   end

   assign bus_s.ack = ack_q;
   assign bus_s.dat_r = dat_q;

endmodule

/* logic/byte_multiplexer.sv */
`timescale 1ns/1ps

module byte_multiplexer import console_pkg::*; (
   input logic clk,
   input logic arst_n_i,
   wb_bus_if.slave word_s,
   wb_bus_if.master byte_m
);

   typedef enum logic [1:0] {
      mux_idle, // first byte cycle also runs here
      mux_low,
      mux_ack
   } mux_state_e;

   mux_state_e state_q;
   word_t rd_q;
   logic word_req;
   logic lane_low;
   logic byte_stb;

   assign word_req = word_s.cyc && word_s.stb;

   // the even byte goes first, so the odd lane is current only when alone or second
   assign lane_low = (state_q == mux_low) || !word_s.sel[1];
   assign byte_stb = (state_q == mux_low) || (state_q == mux_idle && word_req && |word_s.sel);

   assign byte_m.cyc = byte_stb;
   assign byte_m.stb = byte_stb;
   assign byte_m.we = word_s.we;
   assign byte_m.adr = {word_s.adr[13:0], lane_low}; // word address times two, plus lane
   assign byte_m.sel = 1'b1;
   assign byte_m.dat_w = lane_low ? word_s.dat_w[7:0] : word_s.dat_w[15:8];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= mux_idle;
      end else begin
         case (state_q)
            mux_idle: begin
               if (word_req && !(|word_s.sel)) begin
                  state_q <= mux_ack; // no lane selected, nothing to fetch
               end else if (byte_m.ack) begin
                  state_q <= (!lane_low && word_s.sel[0]) ? mux_low : mux_ack;
               end
            end
            mux_low: if (byte_m.ack) state_q <= mux_ack;
            default: state_q <= mux_idle;
         endcase
      end
   end

   // unselected lanes keep the all ones preset from the idle cycle
   always_ff @(posedge clk) begin
      if (byte_m.ack) begin
         if (lane_low) rd_q[7:0] <= byte_m.dat_r;
         else rd_q[15:8] <= byte_m.dat_r;
      end else if (state_q == mux_idle) begin
         rd_q <= '1;
      end
   end

   assign word_s.dat_r = rd_q;
   assign word_s.ack = (state_q == mux_ack);

endmodule

/* logic/scratchpad_ram.sv */
`timescale 1ns/1ps

module scratchpad_ram import console_pkg::*; (
   input logic clk,
   input logic arst_n_i,
   wb_bus_if.slave bus_s
);

   localparam int idx_w = $clog2(scratch_words);

   word_t mem [scratch_words];
   word_t dat_q;
   logic ack_q;
   logic access;
   logic [idx_w-1:0] idx;

   assign access = bus_s.cyc && bus_s.stb && !ack_q; // once per access
   assign idx = bus_s.adr[idx_w-1:0];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) ack_q <= 1'b0;
      else ack_q <= access;
   end

   always_ff @(posedge clk) begin
      if (access && bus_s.we) begin
         if (bus_s.sel[1]) mem[idx][15:8] <= bus_s.dat_w[15:8]; // even byte
         if (bus_s.sel[0]) mem[idx][7:0] <= bus_s.dat_w[7:0];
      end
      dat_q <= mem[idx];
   end

   assign bus_s.ack = ack_q;
   assign bus_s.dat_r = dat_q;

endmodule

/* logic/console_rom.sv */
`timescale 1ns/1ps

module console_rom import console_pkg::*; (
   input logic clk,
   input logic arst_n_i,
   wb_bus_if.slave bus_s
);

   localparam int idx_w = $clog2(rom_words);

   word_t mem [rom_words];
   word_t dat_q;
   logic ack_q;

   initial $readmemh(rom_image, mem);

   // writes are acked like reads but never reach the array
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) ack_q <= 1'b0;
      else ack_q <= bus_s.cyc && bus_s.stb && !ack_q;
   end

   always_ff @(posedge clk) begin
      dat_q <= mem[bus_s.adr[idx_w-1:0]]; // upper address bits mirror the image
   end

   assign bus_s.ack = ack_q;
   assign bus_s.dat_r = dat_q;

endmodule

/* logic/address_decoder.sv */
`timescale 1ns/1ps

module address_decoder import console_pkg::*; (
   input logic clk,
   input logic arst_n_i,
   wb_bus_if.slave shared_i,
   wb_bus_if.master rom_o,
   wb_bus_if.master scratch_o,
   wb_bus_if.master exp_o
);

   logic [15:0] byte_adr;
   region_e region;
   logic none_ack_q;

   // wraps around, so one compare covers both ends of the window
   function automatic logic in_window(logic [15:0] adr, logic [15:0] base,
                                      logic [15:0] size);
      logic [15:0] offset;
      offset = adr - base;
      return offset < size;
   endfunction

   assign byte_adr = {shared_i.adr, 1'b0};

   always_comb begin
      if (in_window(byte_adr, rom_base, rom_size)) region = region_rom;
      else if (in_window(byte_adr, exp_base, exp_size)) region = region_exp;
      else if (in_window(byte_adr, scratch_base, scratch_size)) region = region_scratch;
      else region = region_none;
   end

   assign rom_o.cyc = shared_i.cyc && (region == region_rom);
   assign rom_o.stb = shared_i.stb && (region == region_rom);
   assign scratch_o.cyc = shared_i.cyc && (region == region_scratch);
   assign scratch_o.stb = shared_i.stb && (region == region_scratch);
   assign exp_o.cyc = shared_i.cyc && (region == region_exp);
   assign exp_o.stb = shared_i.stb && (region == region_exp);

   assign {rom_o.we, scratch_o.we, exp_o.we} = {3{shared_i.we}};
   assign {rom_o.adr, scratch_o.adr, exp_o.adr} = {3{shared_i.adr}};
   assign {rom_o.sel, scratch_o.sel, exp_o.sel} = {3{shared_i.sel}};
   assign {rom_o.dat_w, scratch_o.dat_w, exp_o.dat_w} = {3{shared_i.dat_w}};

   // nothing answers an unmapped address, so the decoder acks it itself
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         none_ack_q <= 1'b0;
      end else begin
         none_ack_q <= shared_i.cyc && shared_i.stb && (region == region_none) && !none_ack_q;
      end
   end

   always_comb begin
      case (region)
         region_rom: begin
            shared_i.dat_r = rom_o.dat_r;
            shared_i.ack = rom_o.ack;
         end
         region_scratch: begin
            shared_i.dat_r = scratch_o.dat_r;
            shared_i.ack = scratch_o.ack;
         end
         region_exp: begin
            shared_i.dat_r = exp_o.dat_r;
            shared_i.ack = exp_o.ack;
         end
         default: begin
            shared_i.dat_r = '1; // open bus reads as all ones
            shared_i.ack = none_ack_q;
         end
      endcase
   end

endmodule

/* logic/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
   input logic clk,
   input logic arst_n_i,
   wb_bus_if.slave cpu_m,
   wb_bus_if.slave dbg_m,
   wb_bus_if.master shared_o
);

   logic [1:0] gnt_q; // bit 0 cpu, bit 1 debug host
   logic [1:0] gnt_d;
   logic last_dbg_q; // debug host was served last
   logic last_dbg;
   logic req_cpu;
   logic req_dbg;
   logic bus_free;

   assign req_cpu = cpu_m.cyc && cpu_m.stb;
   assign req_dbg = dbg_m.cyc && dbg_m.stb;

   // the grant may move while the shared bus is idle or in its ack cycle
   assign bus_free = !shared_o.cyc || shared_o.ack;
   assign last_dbg = shared_o.ack ? gnt_q[1] : last_dbg_q;

   always_comb begin
      gnt_d = gnt_q;
      if (bus_free) begin
         if (req_cpu && req_dbg) begin
            gnt_d = last_dbg ? 2'b01 : 2'b10; // turn goes to the other master
         end else begin
            gnt_d = {req_dbg, req_cpu};
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gnt_q <= 2'b00;
         last_dbg_q <= 1'b0;
      end else begin
         gnt_q <= gnt_d;
         if (shared_o.ack) last_dbg_q <= gnt_q[1];
      end
   end

   assign shared_o.cyc = (gnt_q[0] && cpu_m.cyc) || (gnt_q[1] && dbg_m.cyc);
   assign shared_o.stb = (gnt_q[0] && cpu_m.stb) || (gnt_q[1] && dbg_m.stb);
   assign shared_o.we = gnt_q[1] ? dbg_m.we : cpu_m.we;
   assign shared_o.adr = gnt_q[1] ? dbg_m.adr : cpu_m.adr;
   assign shared_o.sel = gnt_q[1] ? dbg_m.sel : cpu_m.sel;
   assign shared_o.dat_w = gnt_q[1] ? dbg_m.dat_w : cpu_m.dat_w;

   assign cpu_m.ack = gnt_q[0] && shared_o.ack;
   assign dbg_m.ack = gnt_q[1] && shared_o.ack;
   assign cpu_m.dat_r = gnt_q[0] ? shared_o.dat_r : '0;
   assign dbg_m.dat_r = gnt_q[1] ? shared_o.dat_r : '0;

endmodule

/* logic/wb_bus_if.sv */
`timescale 1ns/1ps

interface wb_bus_if import console_pkg::*; #(
   parameter type data_t = word_t
) ();

   logic cyc;
   logic stb;
   logic we;
   waddr_t adr;
   logic [$bits(data_t)/8-1:0] sel; // high bit is the even byte
   data_t dat_w;
   data_t dat_r;
   logic ack;

   modport master (
      output cyc, stb, we, adr, sel, dat_w,
      input dat_r, ack
   );

   modport slave (
      input cyc, stb, we, adr, sel, dat_w,
      output dat_r, ack
   );

endinterface

/* logic/console_pkg.sv */
package console_pkg;

   // bit 15 of a bus word holds the byte at the even address
   typedef logic [15:0] word_t;
   typedef logic [7:0] byte_t;
   typedef logic [14:0] waddr_t; // byte address without its lowest bit

   typedef enum logic [1:0] {
      region_rom,
      region_scratch,
      region_exp,
      region_none
   } region_e;

   // the console's address map is given in byte addresses
   localparam logic [15:0] rom_base = 16'h0000;
   localparam logic [15:0] rom_size = 16'h2000;
   localparam int rom_words = 16; // mirrored over the whole ROM region

   localparam logic [15:0] exp_base = 16'h2000;
   localparam logic [15:0] exp_size = 16'h2000;
   localparam int exp_bytes = 256;

   localparam logic [15:0] scratch_base = 16'h8000;
   localparam logic [15:0] scratch_size = 16'h0400;
   localparam int scratch_words = 128;

   // the image path is relative to the directory the simulation runs in
   localparam string rom_image = "logic/console_rom.hex";

endpackage
